// File: Bender.yml
package:
  name: exu_pipeline

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/exu_bus_pkg.sv
      - verilog/exu_alu.sv
      - verilog/exu_operand_select.sv
      - verilog/exu_execute_stage.sv
      - verilog/exu_commit_stage.sv
      - verilog/exu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exu_tb.sv

// File: filelist.f
+incdir+verification
verilog/rv_isa_pkg.sv
verilog/exu_bus_pkg.sv
verilog/exu_alu.sv
verilog/exu_operand_select.sv
verilog/exu_execute_stage.sv
verilog/exu_commit_stage.sv
verilog/exu_top.sv
verification/exu_tb.sv

// File: verification/exu_vectors.svh
`ifndef EXU_VECTORS_SVH
`define EXU_VECTORS_SVH

localparam int NUM_VECTORS = 39;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors();
	// fields in order op, src1, src2, branch, load, store, csr
	// then reg1, reg2, pc, imm, csr_rdata, wdata, taken, gap, rnd
	vectors[0] = '{ALU_ADD, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'h7, 32'h100, 32'h0, 32'h0, 32'hc, 1'b0, 4'd0, 1'b0};
	vectors[1] = '{ALU_SUB, SRC1_REG1, SRC2_IMM, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'ha, 32'h0, 32'h104, 32'h3, 32'h0, 32'h7, 1'b0, 4'd0, 1'b0};
	vectors[2] = '{ALU_AND, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'hf0f01234, 32'h0ff000ff, 32'h108, 32'h0, 32'h0, 32'h00f00034, 1'b0, 4'd0, 1'b0};
	vectors[3] = '{ALU_OR, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h0000ff00, 32'h00ff000f, 32'h10c, 32'h0, 32'h0, 32'h00ffff0f, 1'b0, 4'd0, 1'b0};
	vectors[4] = '{ALU_XOR, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'haaaa5555, 32'hffff0000, 32'h110, 32'h0, 32'h0, 32'h55555555, 1'b0, 4'd0, 1'b0};
	vectors[5] = '{ALU_SLL, SRC1_REG1, SRC2_IMM, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h3, 32'h0, 32'h114, 32'h8, 32'h0, 32'h300, 1'b0, 4'd0, 1'b0};
	vectors[6] = '{ALU_SRL, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h80000000, 32'h4, 32'h118, 32'h0, 32'h0, 32'h08000000, 1'b0, 4'd0, 1'b0};
	vectors[7] = '{ALU_SRA, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h80000000, 32'h4, 32'h11c, 32'h0, 32'h0, 32'hf8000000, 1'b0, 4'd0, 1'b0};
	vectors[8] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'hffffffff, 32'h1, 32'h120, 32'h0, 32'h0, 32'h1, 1'b0, 4'd0, 1'b0};
	vectors[9] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'hffffffff, 32'h1, 32'h124, 32'h0, 32'h0, 32'h0, 1'b0, 4'd0, 1'b0};
	// upper immediate style pass through
	vectors[10] = '{ALU_PASS2, SRC1_ZERO, SRC2_IMM, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h0, 32'h0, 32'h128, 32'h12345000, 32'h0, 32'h12345000, 1'b0, 4'd1, 1'b0};
	// jump and link returns pc + 4
	vectors[11] = '{ALU_ADD, SRC1_PC, SRC2_FOUR, BR_JUMP, LD_NONE, ST_NONE, CSR_NONE,
		32'h0, 32'h0, 32'h200, 32'h40, 32'h0, 32'h204, 1'b1, 4'd2, 1'b0};
	vectors[12] = '{ALU_ADD, SRC1_CSR, SRC2_ZERO, BR_NONE, LD_NONE, ST_NONE, CSR_RW,
		32'hdeadbeef, 32'h0, 32'h204, 32'h0, 32'h1800, 32'h1800, 1'b0, 4'd0, 1'b0};
	vectors[13] = '{ALU_ADD, SRC1_CSR, SRC2_ZERO, BR_NONE, LD_NONE, ST_NONE, CSR_RS,
		32'h8, 32'h0, 32'h208, 32'h0, 32'h1800, 32'h1800, 1'b0, 4'd0, 1'b0};
	vectors[14] = '{ALU_ADD, SRC1_ZERO, SRC2_ZERO, BR_NONE, LD_NONE, ST_NONE, CSR_ECALL,
		32'h0, 32'h0, 32'h20c, 32'h0, 32'h0, 32'h0, 1'b0, 4'd1, 1'b0};
	vectors[15] = '{ALU_SUB, SRC1_REG1, SRC2_REG2, BR_BEQ, LD_NONE, ST_NONE, CSR_NONE,
		32'h20, 32'h20, 32'h300, 32'hfffffff0, 32'h0, 32'h0, 1'b1, 4'd0, 1'b0};
	vectors[16] = '{ALU_SUB, SRC1_REG1, SRC2_REG2, BR_BNE, LD_NONE, ST_NONE, CSR_NONE,
		32'h20, 32'h20, 32'h304, 32'h10, 32'h0, 32'h0, 1'b0, 4'd0, 1'b0};
	vectors[17] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BLT, LD_NONE, ST_NONE, CSR_NONE,
		32'hfffffff0, 32'h5, 32'h308, 32'h20, 32'h0, 32'h1, 1'b1, 4'd0, 1'b0};
	vectors[18] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BGE, LD_NONE, ST_NONE, CSR_NONE,
		32'hfffffff0, 32'h5, 32'h30c, 32'h20, 32'h0, 32'h1, 1'b0, 4'd0, 1'b0};
	vectors[19] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BLTU, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'hfffffff0, 32'h310, 32'h20, 32'h0, 32'h1, 1'b1, 4'd0, 1'b0};
	vectors[20] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BGEU, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'hfffffff0, 32'h314, 32'h20, 32'h0, 32'h1, 1'b0, 4'd1, 1'b0};
	// each branch kind with the remaining operand orders
	vectors[21] = '{ALU_SUB, SRC1_REG1, SRC2_REG2, BR_BEQ, LD_NONE, ST_NONE, CSR_NONE,
		32'hfffffff0, 32'h5, 32'h318, 32'h20, 32'h0, 32'hffffffeb, 1'b0, 4'd0, 1'b0};
	vectors[22] = '{ALU_SUB, SRC1_REG1, SRC2_REG2, BR_BEQ, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'hfffffff0, 32'h31c, 32'h20, 32'h0, 32'h15, 1'b0, 4'd0, 1'b0};
	vectors[23] = '{ALU_SUB, SRC1_REG1, SRC2_REG2, BR_BNE, LD_NONE, ST_NONE, CSR_NONE,
		32'hfffffff0, 32'h5, 32'h320, 32'h20, 32'h0, 32'hffffffeb, 1'b1, 4'd0, 1'b0};
	vectors[24] = '{ALU_SUB, SRC1_REG1, SRC2_REG2, BR_BNE, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'hfffffff0, 32'h324, 32'h20, 32'h0, 32'h15, 1'b1, 4'd0, 1'b0};
	vectors[25] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BLT, LD_NONE, ST_NONE, CSR_NONE,
		32'h20, 32'h20, 32'h328, 32'h20, 32'h0, 32'h0, 1'b0, 4'd0, 1'b0};
	vectors[26] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BLT, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'hfffffff0, 32'h32c, 32'h20, 32'h0, 32'h0, 1'b0, 4'd0, 1'b0};
	vectors[27] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BGE, LD_NONE, ST_NONE, CSR_NONE,
		32'h20, 32'h20, 32'h330, 32'h20, 32'h0, 32'h0, 1'b1, 4'd0, 1'b0};
	vectors[28] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BGE, LD_NONE, ST_NONE, CSR_NONE,
		32'h5, 32'hfffffff0, 32'h334, 32'h20, 32'h0, 32'h0, 1'b1, 4'd0, 1'b0};
	vectors[29] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BLTU, LD_NONE, ST_NONE, CSR_NONE,
		32'h20, 32'h20, 32'h338, 32'h20, 32'h0, 32'h0, 1'b0, 4'd0, 1'b0};
	vectors[30] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BLTU, LD_NONE, ST_NONE, CSR_NONE,
		32'hfffffff0, 32'h5, 32'h33c, 32'h20, 32'h0, 32'h0, 1'b0, 4'd0, 1'b0};
	vectors[31] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BGEU, LD_NONE, ST_NONE, CSR_NONE,
		32'h20, 32'h20, 32'h340, 32'h20, 32'h0, 32'h0, 1'b1, 4'd0, 1'b0};
	vectors[32] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BGEU, LD_NONE, ST_NONE, CSR_NONE,
		32'hfffffff0, 32'h5, 32'h344, 32'h20, 32'h0, 32'h0, 1'b1, 4'd0, 1'b0};
	// alu forms the store and load address
	vectors[33] = '{ALU_ADD, SRC1_REG1, SRC2_IMM, BR_NONE, LD_NONE, ST_WORD, CSR_NONE,
		32'h1000, 32'hcafef00d, 32'h400, 32'h10, 32'h0, 32'h1010, 1'b0, 4'd0, 1'b0};
	vectors[34] = '{ALU_ADD, SRC1_REG1, SRC2_IMM, BR_NONE, LD_NONE, ST_BYTE, CSR_NONE,
		32'h2000, 32'hab, 32'h404, 32'h1, 32'h0, 32'h2001, 1'b0, 4'd3, 1'b0};
	vectors[35] = '{ALU_ADD, SRC1_REG1, SRC2_IMM, BR_NONE, LD_LW, ST_NONE, CSR_NONE,
		32'h3000, 32'h0, 32'h408, 32'h8, 32'h0, 32'h3008, 1'b0, 4'd0, 1'b0};
	// random operands checked against the models
	vectors[36] = '{ALU_ADD, SRC1_REG1, SRC2_REG2, BR_NONE, LD_NONE, ST_NONE, CSR_NONE,
		32'h0, 32'h0, 32'h500, 32'h0, 32'h0, 32'h0, 1'b0, 4'd0, 1'b1};
	vectors[37] = '{ALU_SLT, SRC1_REG1, SRC2_REG2, BR_BLT, LD_NONE, ST_NONE, CSR_NONE,
		32'h0, 32'h0, 32'h504, 32'h8, 32'h0, 32'h0, 1'b0, 4'd0, 1'b1};
	vectors[38] = '{ALU_SLTU, SRC1_REG1, SRC2_REG2, BR_BGEU, LD_NONE, ST_NONE, CSR_NONE,
		32'h0, 32'h0, 32'h508, 32'hc, 32'h0, 32'h0, 1'b0, 4'd0, 1'b1};
endtask

`endif

// File: verification/exu_tb.sv
`timescale 1ns/1ns

module exu_tb
	import rv_isa_pkg::*;
	import exu_bus_pkg::*;
();

	localparam int CLK_PERIOD = 10;

	// stimulus plus the results that need an independent value
	typedef struct packed {
		alu_op_t     op;
		src1_sel_t   s1;
		src2_sel_t   s2;
		branch_t     br;
		load_t       ld;
		store_t      st;
		csr_op_t     csr;
		logic [31:0] reg1;
		logic [31:0] reg2;
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] csr_rdata;
		logic [31:0] wdata;
		logic        taken;
		logic [3:0]  gap;
		logic        rnd;
	} vector_t;

	`include "exu_vectors.svh"

	logic    clock;
	logic    reset;
	issue_t  issue_i;
	logic    issue_valid_i;
	commit_t commit_o;
	logic    commit_valid_o;

	commit_t expected_q[$];
	int      due_q[$];
	commit_t want;
	int      due;
	int      cycle;
	int      errors;
	int      checks;
	int      limit;
	int      row;
	integer  seed;
	logic    table_ready;
	issue_t  iss;

	exu_top #(
		.XLEN_P(32)
	) uut (
		.clock         (clock),
		.reset         (reset),
		.issue_i       (issue_i),
		.issue_valid_i (issue_valid_i),
		.commit_o      (commit_o),
		.commit_valid_o(commit_valid_o)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] pick_src1(issue_t i);
		case (i.src1_sel)
			SRC1_REG1: return i.reg1;
			SRC1_PC:   return i.pc;
			SRC1_CSR:  return i.csr_rdata;
			default:   return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] pick_src2(issue_t i);
		case (i.src2_sel)
			SRC2_REG2: return i.reg2;
			SRC2_IMM:  return i.imm;
			SRC2_FOUR: return 32'd4;
			default:   return 32'h0;
		endcase
	endfunction

	// reference arithmetic from the isa definitions
	function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a - b;
			ALU_AND:   return a & b;
			ALU_OR:    return a | b;
			ALU_XOR:   return a ^ b;
			ALU_SLL:   return a << b[4:0];
			ALU_SRL:   return a >> b[4:0];
			ALU_SRA:   return $signed(a) >>> b[4:0];
			ALU_SLT:   return {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:  return {31'b0, a < b};
			ALU_PASS2: return b;
			default:   return 32'h0;
		endcase
	endfunction

	function automatic logic branch_model(branch_t br, logic [31:0] a, logic [31:0] b);
		case (br)
			BR_BEQ:  return a == b;
			BR_BNE:  return a != b;
			BR_BLT:  return $signed(a) < $signed(b);
			BR_BGE:  return $signed(a) >= $signed(b);
			BR_BLTU: return a < b;
			BR_BGEU: return a >= b;
			BR_JUMP: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic issue_t build_issue(vector_t v, int idx);
		issue_t i;
		i.reg1      = v.reg1;
		i.reg2      = v.reg2;
		i.pc        = v.pc;
		i.imm       = v.imm;
		i.csr_rdata = v.csr_rdata;
		i.alu_op    = v.op;
		i.src1_sel  = v.s1;
		i.src2_sel  = v.s2;
		i.branch    = v.br;
		i.load      = v.ld;
		i.store     = v.st;
		i.csr_op    = v.csr;
		// only jumps and plain ops write a register
		i.wd        = (v.st == ST_NONE) && (v.br == BR_NONE || v.br == BR_JUMP);
		i.wreg      = 5'(idx + 1);
		return i;
	endfunction

	function automatic commit_t expected_commit(vector_t v, issue_t i);
		commit_t     c;
		logic        ecall;
		logic [31:0] a;
		logic [31:0] b;
		ecall           = (i.csr_op == CSR_ECALL);
		a               = pick_src1(i);
		b               = pick_src2(i);
		c.wd            = i.wd & ~ecall;
		c.wreg          = i.wreg;
		c.wdata         = v.rnd ? alu_model(i.alu_op, a, b) : v.wdata;
		c.load          = i.load;
		c.mem_wen       = (i.store != ST_NONE);
		c.store         = i.store;
		c.mem_wdata     = i.reg2;
		c.csr_op        = i.csr_op;
		c.csr_wdata     = (i.csr_op == CSR_RW) ? i.reg1 :
			(i.csr_op == CSR_RS) ? (i.reg1 | i.csr_rdata) : 32'h0;
		c.branch_taken  = v.rnd ? branch_model(i.branch, a, b) : v.taken;
		c.branch_target = i.pc + i.imm;
		c.trap          = ecall;
		c.trap_cause    = ecall ? MCAUSE_ECALL_M : 32'h0;
		return c;
	endfunction

	// monitor, counts falling edges so the latency check has a time base
	always @(negedge clock) begin
		cycle = cycle + 1;
		if (!reset) begin
			if (commit_valid_o !== 1'b0 && commit_valid_o !== 1'b1) begin
				errors = errors + 1;
				$display("commit_valid_o is unknown at %0t", $time);
			end else if (commit_valid_o) begin
				if (expected_q.size() == 0) begin
					errors = errors + 1;
					$display("unexpected result on commit_o at %0t, nothing was pending", $time);
				end else begin
					want = expected_q.pop_front();
					due  = due_q.pop_front();
					compare("latency", cycle, due);
					compare("wd", commit_o.wd, want.wd);
					compare("wreg", commit_o.wreg, want.wreg);
					compare("wdata", commit_o.wdata, want.wdata);
					compare("load", commit_o.load, want.load);
					compare("mem_wen", commit_o.mem_wen, want.mem_wen);
					compare("store", commit_o.store, want.store);
					compare("mem_wdata", commit_o.mem_wdata, want.mem_wdata);
					compare("csr_op", commit_o.csr_op, want.csr_op);
					compare("csr_wdata", commit_o.csr_wdata, want.csr_wdata);
					compare("branch_taken", commit_o.branch_taken, want.branch_taken);
					compare("branch_target", commit_o.branch_target, want.branch_target);
					compare("trap", commit_o.trap, want.trap);
					compare("trap_cause", commit_o.trap_cause, want.trap_cause);
				end
			end
		end
	end

	initial begin
		wait (table_ready === 1'b1);
		limit = NUM_VECTORS + 10;
		for (int k = 0; k < NUM_VECTORS; k++) begin
			limit = limit + vectors[k].gap;
		end
		#(limit * CLK_PERIOD);
		$display("timeout: results still missing after %0d clock periods", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		reset         = 1'b1;
		issue_valid_i = 1'b0;
		issue_i       = '0;
		cycle         = 0;
		errors        = 0;
		checks        = 0;
		seed          = 67;
		table_ready   = 1'b0;
		load_vectors();
		table_ready = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		for (row = 0; row < NUM_VECTORS; row++) begin
			iss = build_issue(vectors[row], row);
			if (vectors[row].rnd) begin
				iss.reg1 = $random(seed);
				iss.reg2 = $random(seed);
			end
			@(posedge clock);
			issue_i       <= iss;
			issue_valid_i <= 1'b1;
			expected_q.push_back(expected_commit(vectors[row], iss));
			// sampled on the next edge, then three stage registers
			due_q.push_back(cycle + 4);
			repeat (vectors[row].gap) begin
				@(posedge clock);
				issue_valid_i <= 1'b0;
			end
		end
		@(posedge clock);
		issue_valid_i <= 1'b0;
		while (expected_q.size() != 0) begin
			@(negedge clock);
		end
		repeat (2) @(negedge clock);
		$display("errors: %0d, checks: %0d, rows: %0d", errors, checks, NUM_VECTORS);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: verilog/exu_alu.sv
`timescale 1ns/1ns

module exu_alu
	import rv_isa_pkg::*;
#(
	parameter int XLEN_P = 32
) (
	input  logic [XLEN_P-1:0] src1_i,
	input  logic [XLEN_P-1:0] src2_i,
	input  alu_op_t           alu_op_i,
	output logic [XLEN_P-1:0] result_o,
	output logic              zero_o,
	output logic              less_o
);

	// shift amount width follows the word size
	localparam int SHAMT_W = $clog2(XLEN_P);

	logic [XLEN_P-1:0]  sum;
	logic [XLEN_P-1:0]  diff;
	logic [SHAMT_W-1:0] shamt;
	logic               lt_signed;
	logic               lt_unsigned;

	assign sum   = src1_i + src2_i;
	assign diff  = src1_i - src2_i;
	assign shamt = src2_i[SHAMT_W-1:0];

	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	// flags for the branch unit
	assign zero_o = (diff == '0);
	assign less_o = (alu_op_i == ALU_SLTU) ? lt_unsigned : lt_signed;

	always_comb begin
		case (alu_op_i)
			ALU_ADD: begin
				result_o = sum;
			end
			ALU_SUB: begin
				result_o = diff;
			end
			ALU_AND: begin
				result_o = src1_i & src2_i;
			end
			ALU_OR: begin
				result_o = src1_i | src2_i;
			end
			ALU_XOR: begin
				result_o = src1_i ^ src2_i;
			end
			ALU_SLL: begin
				result_o = src1_i << shamt;
			end
			ALU_SRL: begin
				result_o = src1_i >> shamt;
			end
			// arithmetic shift keeps the sign bit
			ALU_SRA: begin
				result_o = $unsigned($signed(src1_i) >>> shamt);
			end
			ALU_SLT: begin
				result_o = {{(XLEN_P-1){1'b0}}, lt_signed};
			end
			ALU_SLTU: begin
				result_o = {{(XLEN_P-1){1'b0}}, lt_unsigned};
			end
			ALU_PASS2: begin
				result_o = src2_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// File: verilog/exu_bus_pkg.sv
package exu_bus_pkg;
	import rv_isa_pkg::*;

	localparam int XLEN = 32;

	// decoded instruction from the issuer
	typedef struct packed {
		logic [XLEN-1:0] reg1;
		logic [XLEN-1:0] reg2;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] csr_rdata;
		alu_op_t         alu_op;
		src1_sel_t       src1_sel;
		src2_sel_t       src2_sel;
		branch_t         branch;
		load_t           load;
		store_t          store;
		csr_op_t         csr_op;
		logic            wd;
		logic [4:0]      wreg;
	} issue_t;

	// operand select to execute
	typedef struct packed {
		logic [XLEN-1:0] src1;
		logic [XLEN-1:0] src2;
		logic [XLEN-1:0] reg1;
		logic [XLEN-1:0] reg2;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] csr_rdata;
		alu_op_t         alu_op;
		src1_sel_t       src1_sel;
		src2_sel_t       src2_sel;
		branch_t         branch;
		load_t           load;
		store_t          store;
		csr_op_t         csr_op;
		logic            wd;
		logic [4:0]      wreg;
	} opsel_t;

	// execute to commit
	typedef struct packed {
		logic [XLEN-1:0] alu_result;
		logic            branch_taken;
		logic [XLEN-1:0] csr_wdata;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		branch_t         branch;
		load_t           load;
		store_t          store;
		csr_op_t         csr_op;
		logic            wd;
		logic [4:0]      wreg;
	} exec_t;

	typedef struct packed {
		logic            wd;
		logic [4:0]      wreg;
		logic [XLEN-1:0] wdata;
		load_t           load;
		logic            mem_wen;
		store_t          store;
		logic [XLEN-1:0] mem_wdata;
		csr_op_t         csr_op;
		logic [XLEN-1:0] csr_wdata;
		logic            branch_taken;
		logic [XLEN-1:0] branch_target;
		logic            trap;
		logic [XLEN-1:0] trap_cause;
	} commit_t;

endpackage

// File: verilog/exu_commit_stage.sv
`timescale 1ns/1ns

module exu_commit_stage
	import rv_isa_pkg::*;
	import exu_bus_pkg::*;
#(
	parameter int XLEN_P = 32
) (
	input  logic    clock,
	input  logic    reset,
	input  exec_t   exec_i,
	input  logic    exec_valid_i,
	output commit_t commit_o,
	output logic    commit_valid_o
);

	logic [XLEN_P-1:0] branch_target;
	logic              is_ecall;

	// target is pc + imm for every branch kind
	assign branch_target = exec_i.pc + exec_i.imm;
	assign is_ecall      = (exec_i.csr_op == CSR_ECALL);

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid_o <= 1'b0;
		end else begin
			commit_valid_o <= exec_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (exec_valid_i) begin
			// ecall never writes the register file
			commit_o.wd            <= exec_i.wd & ~is_ecall;
			commit_o.wreg          <= exec_i.wreg;
			commit_o.wdata         <= exec_i.alu_result;
			commit_o.load          <= exec_i.load;
			commit_o.mem_wen       <= (exec_i.store != ST_NONE);
			commit_o.store         <= exec_i.store;
			commit_o.mem_wdata     <= exec_i.store_data;
			commit_o.csr_op        <= exec_i.csr_op;
			commit_o.csr_wdata     <= exec_i.csr_wdata;
			commit_o.branch_taken  <= exec_i.branch_taken;
			commit_o.branch_target <= branch_target;
			commit_o.trap          <= is_ecall;
			commit_o.trap_cause    <= is_ecall ? MCAUSE_ECALL_M : '0;
		end
	end

endmodule

// File: verilog/exu_execute_stage.sv
`timescale 1ns/1ns

module exu_execute_stage
	import rv_isa_pkg::*;
	import exu_bus_pkg::*;
#(
	parameter int XLEN_P = 32
) (
	input  logic   clock,
	input  logic   reset,
	input  opsel_t opsel_i,
	input  logic   opsel_valid_i,
	output exec_t  exec_o,
	output logic   exec_valid_o
);

	logic [XLEN_P-1:0] alu_result;
	logic              alu_zero;
	logic              alu_less;
	logic              branch_taken;
	logic [XLEN_P-1:0] csr_wdata;

	// issuer picks sub or slt/sltu to match the branch kind
	exu_alu #(
		.XLEN_P(XLEN_P)
	) u_alu (
		.src1_i  (opsel_i.src1),
		.src2_i  (opsel_i.src2),
		.alu_op_i(opsel_i.alu_op),
		.result_o(alu_result),
		.zero_o  (alu_zero),
		.less_o  (alu_less)
	);

	// branch decision
	always_comb begin
		case (opsel_i.branch)
			BR_BEQ:  branch_taken = alu_zero;
			BR_BNE:  branch_taken = ~alu_zero;
			BR_BLT:  branch_taken = alu_less;
			BR_BGE:  branch_taken = ~alu_less;
			BR_BLTU: branch_taken = alu_less;
			BR_BGEU: branch_taken = ~alu_less;
			BR_JUMP: branch_taken = 1'b1;
			default: branch_taken = 1'b0;
		endcase
	end

	// csr write data
	always_comb begin
		case (opsel_i.csr_op)
			CSR_RW:  csr_wdata = opsel_i.reg1;
			CSR_RS:  csr_wdata = opsel_i.reg1 | opsel_i.csr_rdata;
			default: csr_wdata = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			exec_valid_o <= 1'b0;
		end else begin
			exec_valid_o <= opsel_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (opsel_valid_i) begin
			exec_o.alu_result   <= alu_result;
			exec_o.branch_taken <= branch_taken;
			exec_o.csr_wdata    <= csr_wdata;
			// reg2 goes on as store data
			exec_o.store_data   <= opsel_i.reg2;
			exec_o.pc           <= opsel_i.pc;
			exec_o.imm          <= opsel_i.imm;
			exec_o.branch       <= opsel_i.branch;
			exec_o.load         <= opsel_i.load;
			exec_o.store        <= opsel_i.store;
			exec_o.csr_op       <= opsel_i.csr_op;
			exec_o.wd           <= opsel_i.wd;
			exec_o.wreg         <= opsel_i.wreg;
		end
	end

endmodule

// File: verilog/exu_operand_select.sv
`timescale 1ns/1ns

module exu_operand_select
	import rv_isa_pkg::*;
	import exu_bus_pkg::*;
#(
	parameter int XLEN_P = 32
) (
	input  logic   clock,
	input  logic   reset,
	input  issue_t issue_i,
	input  logic   issue_valid_i,
	output opsel_t opsel_o,
	output logic   opsel_valid_o
);

	logic [XLEN_P-1:0] src1;
	logic [XLEN_P-1:0] src2;

	// source one mux
	always_comb begin
		case (issue_i.src1_sel)
			SRC1_ZERO: src1 = '0;
			SRC1_REG1: src1 = issue_i.reg1;
			SRC1_PC:   src1 = issue_i.pc;
			SRC1_CSR:  src1 = issue_i.csr_rdata;
			default:   src1 = '0;
		endcase
	end

	// source two mux, constant four gives pc + 4 for jal/jalr
	always_comb begin
		case (issue_i.src2_sel)
			SRC2_ZERO: src2 = '0;
			SRC2_REG2: src2 = issue_i.reg2;
			SRC2_IMM:  src2 = issue_i.imm;
			SRC2_FOUR: src2 = XLEN_P'(4);
			default:   src2 = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			opsel_valid_o <= 1'b0;
		end else begin
			opsel_valid_o <= issue_valid_i;
		end
	end

	// payload only loads on a valid issue
	always_ff @(posedge clock) begin
		if (issue_valid_i) begin
			opsel_o.src1      <= src1;
			opsel_o.src2      <= src2;
			opsel_o.reg1      <= issue_i.reg1;
			opsel_o.reg2      <= issue_i.reg2;
			opsel_o.pc        <= issue_i.pc;
			opsel_o.imm       <= issue_i.imm;
			opsel_o.csr_rdata <= issue_i.csr_rdata;
			opsel_o.alu_op    <= issue_i.alu_op;
			opsel_o.src1_sel  <= issue_i.src1_sel;
			opsel_o.src2_sel  <= issue_i.src2_sel;
			opsel_o.branch    <= issue_i.branch;
			opsel_o.load      <= issue_i.load;
			opsel_o.store     <= issue_i.store;
			opsel_o.csr_op    <= issue_i.csr_op;
			opsel_o.wd        <= issue_i.wd;
			opsel_o.wreg      <= issue_i.wreg;
		end
	end

endmodule

// File: verilog/exu_top.sv
`timescale 1ns/1ns

module exu_top
	import exu_bus_pkg::*;
#(
	parameter int XLEN_P = 32
) (
	input  logic    clock,
	input  logic    reset,
	input  issue_t  issue_i,
	input  logic    issue_valid_i,
	output commit_t commit_o,
	output logic    commit_valid_o
);

	opsel_t opsel;
	logic   opsel_valid;
	exec_t  exec;
	logic   exec_valid;

	// three stage chain, forward only
	exu_operand_select #(
		.XLEN_P(XLEN_P)
	) u_operand_select (
		.clock        (clock),
		.reset        (reset),
		.issue_i      (issue_i),
		.issue_valid_i(issue_valid_i),
		.opsel_o      (opsel),
		.opsel_valid_o(opsel_valid)
	);

	exu_execute_stage #(
		.XLEN_P(XLEN_P)
	) u_execute_stage (
		.clock        (clock),
		.reset        (reset),
		.opsel_i      (opsel),
		.opsel_valid_i(opsel_valid),
		.exec_o       (exec),
		.exec_valid_o (exec_valid)
	);

	exu_commit_stage #(
		.XLEN_P(XLEN_P)
	) u_commit_stage (
		.clock         (clock),
		.reset         (reset),
		.exec_i        (exec),
		.exec_valid_i  (exec_valid),
		.commit_o      (commit_o),
		.commit_valid_o(commit_valid_o)
	);

endmodule

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	// alu operation select
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_SLL   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_SLT   = 4'd8,
		ALU_SLTU  = 4'd9,
		ALU_PASS2 = 4'd10
	} alu_op_t;

	// alu source one
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'd0,
		SRC1_REG1 = 2'd1,
		SRC1_PC   = 2'd2,
		SRC1_CSR  = 2'd3
	} src1_sel_t;

	// alu source two, four is for link addresses
	typedef enum logic [1:0] {
		SRC2_ZERO = 2'd0,
		SRC2_REG2 = 2'd1,
		SRC2_IMM  = 2'd2,
		SRC2_FOUR = 2'd3
	} src2_sel_t;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6,
		BR_JUMP = 3'd7
	} branch_t;

	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_BYTE = 2'd1,
		ST_HALF = 2'd2,
		ST_WORD = 2'd3
	} store_t;

	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1,
		LD_LH   = 3'd2,
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4,
		LD_LHU  = 3'd5
	} load_t;

	typedef enum logic [2:0] {
		CSR_NONE  = 3'd0,
		CSR_RW    = 3'd1,
		CSR_RS    = 3'd2,
		CSR_ECALL = 3'd3
	} csr_op_t;

	// machine mode environment call
	localparam logic [31:0] MCAUSE_ECALL_M = 32'd11;

endpackage
